/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_issue_core
FILELIST = sources.f

.PHONY: simulate clean

# build, run, and fail unless the pass message shows up
simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* hw/alu_pipe.sv */
// ==========================================================================
// two-stage alu, fully pipelined, never stalls
// stage 1 latches operands, stage 2 latches the result
// arithmetic wraps modulo 2^DATA_W
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module alu_pipe import issue_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // issued instruction and its operands
  input  logic    iss_valid_i,
  input  alu_op_e iss_op_i,
  input  preg_t   iss_pdest_i,
  input  data_t   iss_imm_i,
  input  data_t   src0_data_i,
  input  data_t   src1_data_i,
  // writeback broadcast
  output logic    wb_valid_o,
  output preg_t   wb_pdest_o,
  output data_t   wb_data_o
);

  // stage 1
  logic    s1_valid_q;
  alu_op_e s1_op_q;
  preg_t   s1_pdest_q;
  data_t   s1_a_q;
  data_t   s1_b_q;
  // stage 2
  logic    s2_valid_q;
  preg_t   s2_pdest_q;
  data_t   s2_data_q;
  data_t   alu_res;

  // valid bits of both stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= iss_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // addi swaps the immediate in for source 1
  always_ff @(posedge clk) begin
    s1_op_q    <= iss_op_i;
    s1_pdest_q <= iss_pdest_i;
    s1_a_q     <= src0_data_i;
    s1_b_q     <= (iss_op_i == OP_ADDI) ? iss_imm_i : src1_data_i;
  end

  always_comb begin
    case (s1_op_q)
      OP_SUB:  alu_res = s1_a_q - s1_b_q;
      OP_AND:  alu_res = s1_a_q & s1_b_q;
      OP_XOR:  alu_res = s1_a_q ^ s1_b_q;
      // add and addi share the adder
      default: alu_res = s1_a_q + s1_b_q;
    endcase
  end

  always_ff @(posedge clk) begin
    s2_pdest_q <= s1_pdest_q;
    s2_data_q  <= alu_res;
  end

  assign wb_valid_o = s2_valid_q;
  assign wb_pdest_o = s2_pdest_q;
  assign wb_data_o  = s2_data_q;

endmodule : alu_pipe

`default_nettype wire

/* hw/issue_core_top.sv */
// ==========================================================================
// issue subsystem top: scoreboard, in-order station, register file, alu
// caller owns tag allocation and must not reuse a tag still in flight
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module issue_core_top import issue_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // dispatch port
  input  logic    disp_valid_i,
  input  alu_op_e disp_op_i,
  input  preg_t   disp_psrc0_i,
  input  preg_t   disp_psrc1_i,
  input  preg_t   disp_pdest_i,
  input  data_t   disp_imm_i,
  output logic    disp_ready_o,
  // writeback, also the wakeup bus
  output logic    wb_valid_o,
  output preg_t   wb_pdest_o,
  output data_t   wb_data_o
);

  // scoreboard lookup
  logic    src0_rdy;
  logic    src1_rdy;
  // issue bus
  logic    iss_valid;
  alu_op_e iss_op;
  preg_t   iss_psrc0;
  preg_t   iss_psrc1;
  preg_t   iss_pdest;
  data_t   iss_imm;
  // operand read
  data_t   rd0_data;
  data_t   rd1_data;

  prf_scoreboard prf_scoreboard_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .disp_valid_i (disp_valid_i),
    .disp_ready_i (disp_ready_o),
    .disp_pdest_i (disp_pdest_i),
    .disp_psrc0_i (disp_psrc0_i),
    .disp_psrc1_i (disp_psrc1_i),
    .wb_valid_i   (wb_valid_o),
    .wb_pdest_i   (wb_pdest_o),
    .src0_rdy_o   (src0_rdy),
    .src1_rdy_o   (src1_rdy)
  );

  order_rs order_rs_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .disp_valid_i (disp_valid_i),
    .disp_op_i    (disp_op_i),
    .disp_psrc0_i (disp_psrc0_i),
    .disp_psrc1_i (disp_psrc1_i),
    .disp_pdest_i (disp_pdest_i),
    .disp_imm_i   (disp_imm_i),
    .disp_ready_o (disp_ready_o),
    .src0_rdy_i   (src0_rdy),
    .src1_rdy_i   (src1_rdy),
    .wb_valid_i   (wb_valid_o),
    .wb_pdest_i   (wb_pdest_o),
    .iss_valid_o  (iss_valid),
    .iss_op_o     (iss_op),
    .iss_psrc0_o  (iss_psrc0),
    .iss_psrc1_o  (iss_psrc1),
    .iss_pdest_o  (iss_pdest),
    .iss_imm_o    (iss_imm)
  );

  phys_regfile phys_regfile_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd0_addr_i (iss_psrc0),
    .rd1_addr_i (iss_psrc1),
    .rd0_data_o (rd0_data),
    .rd1_data_o (rd1_data),
    .wr_en_i    (wb_valid_o),
    .wr_addr_i  (wb_pdest_o),
    .wr_data_i  (wb_data_o)
  );

  alu_pipe alu_pipe_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .iss_valid_i (iss_valid),
    .iss_op_i    (iss_op),
    .iss_pdest_i (iss_pdest),
    .iss_imm_i   (iss_imm),
    .src0_data_i (rd0_data),
    .src1_data_i (rd1_data),
    .wb_valid_o  (wb_valid_o),
    .wb_pdest_o  (wb_pdest_o),
    .wb_data_o   (wb_data_o)
  );

endmodule : issue_core_top

`default_nettype wire

/* hw/issue_pkg.sv */
// ==========================================================================
// shared widths, depths and types of the issue subsystem
// depths are fixed here; RS_DEPTH must stay a power of two so the
// queue pointers wrap without extra logic
// ==========================================================================
`default_nettype none

package issue_pkg;

  // physical register file geometry
  localparam int PREG_NUM = 16;
  localparam int PREG_W   = 4;
  localparam int DATA_W   = 16;

  // reservation station geometry
  localparam int RS_DEPTH = 4;
  localparam int RS_PTR_W = 2;
  // one extra bit so a full queue is distinct from an empty one
  localparam int RS_CNT_W = 3;

  typedef logic [PREG_W-1:0]   preg_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [RS_PTR_W-1:0] rs_ptr_t;
  typedef logic [RS_CNT_W-1:0] rs_cnt_t;

  // alu operations
  // OP_ADDI takes the immediate in place of source 1
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_XOR  = 3'd3,
    OP_ADDI = 3'd4
  } alu_op_e;

endpackage : issue_pkg

`default_nettype wire

/* hw/order_rs.sv */
// ==========================================================================
// in-order reservation station, RS_DEPTH entries in a circular queue
// only the head may issue; a blocked head stalls everything behind it
// one wakeup port; issue has no ready since the alu never stalls
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module order_rs import issue_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // dispatch
  input  logic    disp_valid_i,
  input  alu_op_e disp_op_i,
  input  preg_t   disp_psrc0_i,
  input  preg_t   disp_psrc1_i,
  input  preg_t   disp_pdest_i,
  input  data_t   disp_imm_i,
  output logic    disp_ready_o,
  // operand state from the scoreboard
  input  logic    src0_rdy_i,
  input  logic    src1_rdy_i,
  // wakeup
  input  logic    wb_valid_i,
  input  preg_t   wb_pdest_i,
  // issue
  output logic    iss_valid_o,
  output alu_op_e iss_op_o,
  output preg_t   iss_psrc0_o,
  output preg_t   iss_psrc1_o,
  output preg_t   iss_pdest_o,
  output data_t   iss_imm_o
);

  // ========================================================================
  // queue storage
  // ========================================================================
  // control flags per entry
  logic    ent_valid_q [RS_DEPTH];
  logic    ent_rdy0_q  [RS_DEPTH];
  logic    ent_rdy1_q  [RS_DEPTH];
  // payload per entry
  alu_op_e ent_op_q    [RS_DEPTH];
  preg_t   ent_psrc0_q [RS_DEPTH];
  preg_t   ent_psrc1_q [RS_DEPTH];
  preg_t   ent_pdest_q [RS_DEPTH];
  data_t   ent_imm_q   [RS_DEPTH];

  rs_ptr_t rd_ptr_q;
  rs_ptr_t wr_ptr_q;
  rs_cnt_t cnt_q;
  logic    full;
  logic    push;
  logic    pop;

  assign full         = (cnt_q == rs_cnt_t'(RS_DEPTH));
  assign disp_ready_o = ~full;
  assign push         = disp_valid_i & ~full;
  assign pop          = iss_valid_o;

  // head issues once both operands are present
  assign iss_valid_o = ent_valid_q[rd_ptr_q] & ent_rdy0_q[rd_ptr_q] & ent_rdy1_q[rd_ptr_q];
  assign iss_op_o    = ent_op_q[rd_ptr_q];
  assign iss_psrc0_o = ent_psrc0_q[rd_ptr_q];
  assign iss_psrc1_o = ent_psrc1_q[rd_ptr_q];
  assign iss_pdest_o = ent_pdest_q[rd_ptr_q];
  assign iss_imm_o   = ent_imm_q[rd_ptr_q];

  // ========================================================================
  // pointers and occupancy
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + rs_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + rs_ptr_t'(1);
      end
      // push and pop together leave the count alone
      if (push && !pop) begin
        cnt_q <= cnt_q + rs_cnt_t'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - rs_cnt_t'(1);
      end
    end
  end

  // ========================================================================
  // entry flags for wakeup, free on issue and fill on push
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        ent_valid_q[i] <= 1'b0;
        ent_rdy0_q[i]  <= 1'b0;
        ent_rdy1_q[i]  <= 1'b0;
      end
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        // tag match against the broadcast
        if (wb_valid_i && ent_valid_q[i]) begin
          if (ent_psrc0_q[i] == wb_pdest_i) begin
            ent_rdy0_q[i] <= 1'b1;
          end
          if (ent_psrc1_q[i] == wb_pdest_i) begin
            ent_rdy1_q[i] <= 1'b1;
          end
        end
        if (pop && (rd_ptr_q == rs_ptr_t'(i))) begin
          ent_valid_q[i] <= 1'b0;
        end
        // a push never lands on an occupied head since the queue is not full
        if (push && (wr_ptr_q == rs_ptr_t'(i))) begin
          ent_valid_q[i] <= 1'b1;
          ent_rdy0_q[i]  <= src0_rdy_i;
          // addi has no second register source
          ent_rdy1_q[i]  <= src1_rdy_i | (disp_op_i == OP_ADDI);
        end
      end
    end
  end

  // payload written on push only
  always_ff @(posedge clk) begin
    if (push) begin
      ent_op_q[wr_ptr_q]    <= disp_op_i;
      ent_psrc0_q[wr_ptr_q] <= disp_psrc0_i;
      ent_psrc1_q[wr_ptr_q] <= disp_psrc1_i;
      ent_pdest_q[wr_ptr_q] <= disp_pdest_i;
      ent_imm_q[wr_ptr_q]   <= disp_imm_i;
    end
  end

  a_cnt_bound : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= rs_cnt_t'(RS_DEPTH));

  // head valid flag must agree with the counter
  a_no_issue_empty : assert property (@(posedge clk) disable iff (!rst_n)
    iss_valid_o |-> (cnt_q != '0));

endmodule : order_rs

`default_nettype wire

/* hw/phys_regfile.sv */
// ==========================================================================
// physical register file, PREG_NUM words, all zero after reset
// reads are combinational and see the old value during a write;
// wakeup already delays any consumer past the write edge
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module phys_regfile import issue_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // read ports, addressed by the issue tags
  input  preg_t rd0_addr_i,
  input  preg_t rd1_addr_i,
  output data_t rd0_data_o,
  output data_t rd1_data_o,
  // write port, from the writeback
  input  logic  wr_en_i,
  input  preg_t wr_addr_i,
  input  data_t wr_data_i
);

  data_t regs_q [PREG_NUM];

  // async reads
  assign rd0_data_o = regs_q[rd0_addr_i];
  assign rd1_data_o = regs_q[rd1_addr_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PREG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

endmodule : phys_regfile

`default_nettype wire

/* hw/prf_scoreboard.sv */
// ==========================================================================
// one ready bit per physical register, all set out of reset
// lookup bypasses a same-cycle writeback; writeback wins over a dispatch
// clear of the same tag
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module prf_scoreboard import issue_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // dispatch side
  input  logic  disp_valid_i,
  input  logic  disp_ready_i,
  input  preg_t disp_pdest_i,
  input  preg_t disp_psrc0_i,
  input  preg_t disp_psrc1_i,
  // writeback broadcast
  input  logic  wb_valid_i,
  input  preg_t wb_pdest_i,
  // lookup result
  output logic  src0_rdy_o,
  output logic  src1_rdy_o
);

  logic [PREG_NUM-1:0] rdy_q;
  logic                disp_acc;

  // handshake seen at the dispatch port
  assign disp_acc = disp_valid_i & disp_ready_i;

  // lookup with bypass of the writeback in flight this cycle
  assign src0_rdy_o = rdy_q[disp_psrc0_i] | (wb_valid_i & (wb_pdest_i == disp_psrc0_i));
  assign src1_rdy_o = rdy_q[disp_psrc1_i] | (wb_valid_i & (wb_pdest_i == disp_psrc1_i));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_q <= '1;
    end else begin
      // new producer leaves its value pending
      if (disp_acc) begin
        rdy_q[disp_pdest_i] <= 1'b0;
      end
      // later assignment lets writeback win
      if (wb_valid_i) begin
        rdy_q[wb_pdest_i] <= 1'b1;
      end
    end
  end

  // a destination tag is only handed out once its old value has landed
  a_no_pending_dest : assert property (@(posedge clk) disable iff (!rst_n)
    disp_acc |-> (rdy_q[disp_pdest_i] | (wb_valid_i & (wb_pdest_i == disp_pdest_i))));

endmodule : prf_scoreboard

`default_nettype wire

/* sources.f */
hw/issue_pkg.sv
hw/prf_scoreboard.sv
hw/order_rs.sv
hw/phys_regfile.sv
hw/alu_pipe.sv
hw/issue_core_top.sv
testbench/tb_issue_core.sv

/* testbench/tb_issue_core.sv */
// ==========================================================================
// random dependent instruction stream checked against an in-order model
// tags are allocated here and are not reused while a writeback is in flight
// a tag becomes free again only after the edge that writes it back
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_issue_core import issue_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int NUM_INSTR  = 300;
  // back-to-back chain window that fills the station
  localparam int BURST_LO   = 120;
  localparam int BURST_HI   = 180;

  logic    clk;
  logic    rst_n;
  logic    disp_valid;
  alu_op_e disp_op;
  preg_t   disp_psrc0;
  preg_t   disp_psrc1;
  preg_t   disp_pdest;
  data_t   disp_imm;
  logic    disp_ready;
  logic    wb_valid;
  preg_t   wb_pdest;
  data_t   wb_data;

  // stimulus and reference model state
  integer      seed;
  logic [31:0] rnd;
  data_t       model_regs [PREG_NUM];
  logic        pending    [PREG_NUM];
  preg_t       recent     [4];
  preg_t       exp_tag_q  [$];
  data_t       exp_data_q [$];
  int          n_disp;
  int          n_wb;
  int          n_addi_pend;
  logic        holding;
  logic        saw_full;
  logic        freed;
  preg_t       freed_tag;

  issue_core_top issue_core_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .disp_valid_i (disp_valid),
    .disp_op_i    (disp_op),
    .disp_psrc0_i (disp_psrc0),
    .disp_psrc1_i (disp_psrc1),
    .disp_pdest_i (disp_pdest),
    .disp_imm_i   (disp_imm),
    .disp_ready_o (disp_ready),
    .wb_valid_o   (wb_valid),
    .wb_pdest_o   (wb_pdest),
    .wb_data_o    (wb_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ========================================================================
  // failure reporting and compare tasks
  // ========================================================================
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_tag(input string name, input preg_t got, input preg_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // ========================================================================
  // reference model
  // ========================================================================
  // all results wrap modulo 2^16
  function automatic data_t model_result(alu_op_e op, data_t a, data_t b, data_t imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      // source 1 replaced by the immediate
      OP_ADDI: return a + imm;
      default: return '0;
    endcase
  endfunction

  // new payload on the dispatch port
  // valid stays low while no tag is free
  task automatic gen_instr();
    preg_t start;
    preg_t cand;
    logic  found;
    logic  want;
    found = 1'b0;
    rnd   = $random(seed);
    want  = (n_disp >= BURST_LO && n_disp < BURST_HI) || (rnd[1:0] != 2'b00);
    start = rnd[7:4];
    // first tag with nothing outstanding
    for (int k = 0; k < PREG_NUM; k++) begin
      cand = start + preg_t'(k);
      if (!found && !pending[cand]) begin
        disp_pdest = cand;
        found      = 1'b1;
      end
    end
    rnd      = $random(seed);
    disp_op  = alu_op_e'(3'(rnd % 32'd5));
    disp_imm = rnd[31:16];
    rnd      = $random(seed);
    // mostly recent producers and sometimes any tag
    disp_psrc0 = rnd[2] ? rnd[7:4] : recent[rnd[1:0]];
    disp_psrc1 = rnd[3] ? rnd[11:8] : recent[rnd[13:12]];
    // in the chain window every op depends on the one before
    if (n_disp >= BURST_LO && n_disp < BURST_HI) begin
      disp_psrc0 = recent[0];
    end
    // addi source 1 aimed at a likely pending tag
    if (disp_op == OP_ADDI) begin
      disp_psrc1 = recent[0];
    end
    disp_valid = want & found;
  endtask

  // model update in program order on a transfer
  task automatic accept_instr();
    data_t res;
    res = model_result(disp_op, model_regs[disp_psrc0], model_regs[disp_psrc1], disp_imm);
    if (disp_op == OP_ADDI && pending[disp_psrc1]) begin
      n_addi_pend++;
    end
    exp_tag_q.push_back(disp_pdest);
    exp_data_q.push_back(res);
    model_regs[disp_pdest] = res;
    pending[disp_pdest]    = 1'b1;
    recent[3] = recent[2];
    recent[2] = recent[1];
    recent[1] = recent[0];
    recent[0] = disp_pdest;
    n_disp++;
  endtask

  // writeback against the head of the expected queue
  task automatic observe_wb();
    if (wb_valid) begin
      if (exp_tag_q.size() == 0) begin
        fail_run("writeback seen with no instruction outstanding");
      end
      check_tag("wb_pdest_o", wb_pdest, exp_tag_q[0]);
      check_data("wb_data_o", wb_data, exp_data_q[0]);
      exp_tag_q.delete(0);
      exp_data_q.delete(0);
      freed     = 1'b1;
      freed_tag = wb_pdest;
      n_wb++;
    end
  endtask

  // ========================================================================
  // main sequence
  // ========================================================================
  initial begin
    seed        = 32'hca88cd2a;
    rst_n       = 1'b0;
    disp_valid  = 1'b0;
    disp_op     = OP_ADD;
    disp_psrc0  = '0;
    disp_psrc1  = '0;
    disp_pdest  = '0;
    disp_imm    = '0;
    n_disp      = 0;
    n_wb        = 0;
    n_addi_pend = 0;
    holding     = 1'b0;
    saw_full    = 1'b0;
    freed       = 1'b0;
    freed_tag   = '0;
    for (int i = 0; i < PREG_NUM; i++) begin
      model_regs[i] = '0;
      pending[i]    = 1'b0;
    end
    for (int k = 0; k < 4; k++) begin
      recent[k] = preg_t'(k);
    end
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet outputs before the first dispatch
    repeat (4) begin
      @(negedge clk);
      check_bit("wb_valid_o", wb_valid, 1'b0);
      check_bit("disp_ready_o", disp_ready, 1'b1);
    end

    while (n_wb < NUM_INSTR) begin
      @(negedge clk);
      observe_wb();
      // payload held while the port is blocked
      if (!holding) begin
        if (n_disp < NUM_INSTR) begin
          gen_instr();
        end else begin
          disp_valid = 1'b0;
        end
      end
      // ready only moves on the rising edge
      #1;
      // fewer than RS_DEPTH outstanding leaves a free slot
      if ((n_disp - n_wb) < RS_DEPTH) begin
        check_bit("disp_ready_o", disp_ready, 1'b1);
      end
      if (!disp_ready) begin
        saw_full = 1'b1;
      end
      if (disp_valid && disp_ready) begin
        accept_instr();
      end
      holding = disp_valid & ~disp_ready;
      // tag reusable only after its write edge
      if (freed) begin
        pending[freed_tag] = 1'b0;
        freed              = 1'b0;
      end
    end

    // nothing extra may come out after the last writeback
    disp_valid = 1'b0;
    repeat (8) begin
      @(negedge clk);
      check_bit("wb_valid_o", wb_valid, 1'b0);
    end

    if (n_wb == n_disp && exp_tag_q.size() == 0 && saw_full && n_addi_pend > 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("end of run: %0d dispatched, %0d written back, %0d left",
               n_disp, n_wb, exp_tag_q.size());
      $display("end of run: ready low seen %0b, addi with pending source 1 %0d",
               saw_full, n_addi_pend);
      fail_run("end of run counts or coverage goals not met");
    end
  end

  // ========================================================================
  // watchdog of 20 cycles per instruction plus reset
  // ========================================================================
  initial begin
    #((RST_CYCLES + NUM_INSTR * 20) * CLK_PERIOD);
    fail_run("watchdog expired before all writebacks arrived");
  end

endmodule : tb_issue_core

`default_nettype wire
